/* design/data_store.sv */
/*
 * Data array of the instruction cache, sixteen 256-bit lines.
 * Lines are read combinationally and written whole when a fill arrives.
 */
`timescale 1ns/1ns

module data_store (
    input  logic               clk,
    input  icache_pkg::index_t rd_index,
    input  logic               wr_en,
    input  icache_pkg::index_t wr_index,
    input  icache_pkg::line_t  fill_data,
    output icache_pkg::line_t  r_data
);

    icache_pkg::line_t lines [icache_pkg::NUM_LINES];

    // whole-line write at the end of the fill cycle.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines[wr_index] <= fill_data;
        end
    end

    // read port, valid only together with the tag store.
    assign r_data = lines[rd_index];

endmodule

/* design/fetch_unit.sv */
/*
 * Program counter and lookup driver. Picks one word out of the hit line and
 * registers it with its address. A redirect strobe reloads the program counter.
 */
`timescale 1ns/1ns

module fetch_unit #(
    parameter icache_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_en,
    input  logic               redirect,
    input  icache_pkg::addr_t  redirect_pc,
    input  logic               ic_exp,
    icache_lookup_if.fetch     lookup,
    output logic               inst_valid,
    output ifetch_pkg::inst_t  inst,
    output icache_pkg::addr_t  inst_pc
);

    localparam int SEL_W = $clog2(ifetch_pkg::WORDS_PER_LINE);

    icache_pkg::addr_t                                pc;
    ifetch_pkg::inst_t [ifetch_pkg::WORDS_PER_LINE-1:0] line_words;
    logic [SEL_W-1:0]                                 word_sel;
    logic                                             issue;

    // ####################
    // lookup.
    // ####################

    // no lookup in a redirect cycle, so a stale pc starts no fill.
    assign lookup.ren   = fetch_en && !redirect;
    assign lookup.index = pc[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign lookup.tag   = pc[icache_pkg::TAG_LSB +: icache_pkg::TAG_W];

    assign line_words = lookup.r_data;   // line viewed as eight words.
    assign word_sel   = pc[2 +: SEL_W];  // pc bits 4..2.

    assign issue = fetch_en && !ic_exp && !redirect && lookup.hit;

    // ####################
    // program counter.
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;   // redirect wins over advance.
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
        // a miss or a pause leaves pc where it is.
    end

    // ####################
    // instruction output.
    // ####################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inst    <= line_words[word_sel];
            inst_pc <= pc;
        end
    end

endmodule

/* design/fill_ctrl.sv */
/*
 * Miss handler for the instruction cache. Captures one miss, holds a level
 * request on the memory port until the acknowledge, then returns the line
 * to the cache as a one-cycle fill.
 */
`timescale 1ns/1ns

module fill_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    icache_fill_if.ctrl       fill,
    output logic              mem_req,
    output icache_pkg::addr_t mem_addr,
    input  logic              mem_ack,
    input  icache_pkg::line_t mem_data
);

    ifetch_pkg::fill_state_e state, state_nxt;
    icache_pkg::addr_t       req_addr;  // line address of the pending miss.
    icache_pkg::line_t       line_buf;  // line captured at mem_ack.

    // ####################
    // state machine.
    // ####################
    always_comb begin
        state_nxt = state;
        case (state)
            ifetch_pkg::FILL_IDLE:   if (fill.miss) state_nxt = ifetch_pkg::FILL_WAIT;
            ifetch_pkg::FILL_WAIT:   if (mem_ack) state_nxt = ifetch_pkg::FILL_RETURN;
            ifetch_pkg::FILL_RETURN: state_nxt = ifetch_pkg::FILL_IDLE;
            default:                 state_nxt = ifetch_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ifetch_pkg::FILL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ifetch_pkg::FILL_IDLE && fill.miss) begin
            req_addr <= fill.miss_addr; // misses while busy are dropped.
        end
        if (state == ifetch_pkg::FILL_WAIT && mem_ack) begin
            line_buf <= mem_data;
        end
    end

    assign mem_req  = (state == ifetch_pkg::FILL_WAIT);
    assign mem_addr = req_addr;

    assign fill.ack       = (state == ifetch_pkg::FILL_RETURN);
    assign fill.ack_addr  = req_addr;
    assign fill.fill_data = line_buf;

    // memory answers a request with a single pulse.
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |=> !mem_ack);

    a_no_idle_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ifetch_pkg::FILL_IDLE) |-> !mem_ack);

endmodule

/* design/i_cache.sv */
/*
 * 512-byte direct-mapped instruction cache, 16 lines of 32 bytes.
 * Lookup is combinational. A fill is written at the index and tag of ack_addr.
 */
`timescale 1ns/1ns

module i_cache (
    input  logic   clk,
    input  logic   rst_n,
    icache_lookup_if.cache lookup,
    icache_fill_if.cache   fill,
    input  logic   ic_exp
);

    // zero bits above the tag in a miss address.
    localparam int HIGH_W = icache_pkg::ADDR_W - icache_pkg::TAG_W
                            - icache_pkg::INDEX_W - icache_pkg::INDEX_LSB;

    icache_pkg::tag_t   stored_tag;
    logic               stored_valid;
    logic               line_hit;
    icache_pkg::index_t fill_index;
    icache_pkg::tag_t   fill_tag;

    // fill location comes from the returned address, not the current lookup.
    assign fill_index = fill.ack_addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
    assign fill_tag   = fill.ack_addr[icache_pkg::TAG_LSB +: icache_pkg::TAG_W];

    tag_store u_tag_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (lookup.index),
        .wr_en     (fill.ack),
        .wr_index  (fill_index),
        .wr_tag    (fill_tag),
        .tag       (stored_tag),
        .tag_valid (stored_valid)
    );

    data_store u_data_store (
        .clk       (clk),
        .rd_index  (lookup.index),
        .wr_en     (fill.ack),
        .wr_index  (fill_index),
        .fill_data (fill.fill_data),
        .r_data    (lookup.r_data)
    );

    // ####################
    // hit and miss.
    // ####################
    assign line_hit    = stored_valid && (stored_tag == lookup.tag);
    assign lookup.hit  = line_hit && lookup.ren && !ic_exp && !fill.ack; // no hit in fill cycle.
    assign fill.miss   = !line_hit && lookup.ren && !ic_exp;

    assign fill.miss_addr = {{HIGH_W{1'b0}}, lookup.tag, lookup.index,
                             {icache_pkg::INDEX_LSB{1'b0}}};

    // a filled line is found by a lookup of it in the next cycle.
    a_fill_hits: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(fill.ack) && lookup.ren && !ic_exp
         && lookup.index == $past(fill_index)
         && lookup.tag == $past(fill_tag)) |-> lookup.hit);

endmodule

/* design/icache_if.sv */
/*
 * Lookup interface between the fetch unit and the cache, and fill interface
 * between the cache and the fill controller.
 */
`timescale 1ns/1ns

interface icache_lookup_if;
    logic                 ren;    // lookup enable.
    icache_pkg::index_t   index;
    icache_pkg::tag_t     tag;
    logic                 hit;
    icache_pkg::line_t    r_data; // line at index.

    modport fetch (output ren, index, tag, input hit, r_data);
    modport cache (input ren, index, tag, output hit, r_data);
endinterface

interface icache_fill_if;
    logic                 miss;      // level while the lookup misses.
    icache_pkg::addr_t    miss_addr; // line aligned.
    logic                 ack;       // one-cycle fill strobe.
    icache_pkg::addr_t    ack_addr;
    icache_pkg::line_t    fill_data;

    modport cache (output miss, miss_addr, input ack, ack_addr, fill_data);
    modport ctrl (input miss, miss_addr, output ack, ack_addr, fill_data);
endinterface

/* design/icache_pkg.sv */
/*
 * Cache geometry and cache data types for the instruction fetch front end.
 * Shared by the cache, the fetch unit and the fill controller through scoped names.
 */

package icache_pkg;

    // ####################
    // geometry.
    // ####################
    localparam int ADDR_W    = 32;  // fetch address width.
    localparam int LINE_W    = 256; // one 32-byte line.
    localparam int INDEX_W   = 4;
    localparam int INDEX_LSB = 5;   // low bit of the index.
    localparam int TAG_W     = 6;
    localparam int TAG_LSB   = 9;   // low bit of the tag, so bits 14..9.
    localparam int NUM_LINES = 16;

    // ####################
    // types.
    // ####################
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LINE_W-1:0]  line_t;

endpackage

/* design/ifetch_pkg.sv */
/*
 * Fetch-side types: the instruction word and the fill controller states.
 */

package ifetch_pkg;

    typedef logic [31:0] inst_t;       // one instruction word.

    localparam int WORDS_PER_LINE = 8; // words in a cache line.

    // fill controller states.
    typedef enum logic [1:0] {
        FILL_IDLE,   // waiting for a miss.
        FILL_WAIT,   // memory request outstanding.
        FILL_RETURN  // line handed to the cache for one cycle.
    } fill_state_e;

endpackage

/* design/ifetch_top.sv */
/*
 * Top level of the instruction fetch front end. Connects the fetch unit,
 * the cache and the fill controller and exposes a plain memory port.
 */
`timescale 1ns/1ns

module ifetch_top #(
    parameter icache_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_en,
    input  logic               redirect,
    input  icache_pkg::addr_t  redirect_pc,
    input  logic               ic_exp,
    input  logic               mem_ack,
    input  icache_pkg::line_t  mem_data,
    output logic               inst_valid,
    output ifetch_pkg::inst_t  inst,
    output icache_pkg::addr_t  inst_pc,
    output logic               mem_req,
    output icache_pkg::addr_t  mem_addr
);

    icache_lookup_if u_lookup_if ();
    icache_fill_if   u_fill_if ();

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ic_exp      (ic_exp),
        .lookup      (u_lookup_if.fetch),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    i_cache u_i_cache (
        .clk    (clk),
        .rst_n  (rst_n),
        .lookup (u_lookup_if.cache),
        .fill   (u_fill_if.cache),
        .ic_exp (ic_exp)
    );

    fill_ctrl u_fill_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .fill     (u_fill_if.ctrl),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

endmodule

/* design/tag_store.sv */
/*
 * Tag array of the instruction cache with one valid bit per line.
 * Combinational read at rd_index, tag write and valid set at wr_index on wr_en.
 */
`timescale 1ns/1ns

module tag_store (
    input  logic               clk,
    input  logic               rst_n,
    input  icache_pkg::index_t rd_index,
    input  logic               wr_en,
    input  icache_pkg::index_t wr_index,
    input  icache_pkg::tag_t   wr_tag,
    output icache_pkg::tag_t   tag,
    output logic               tag_valid
);

    icache_pkg::tag_t                   tags [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0]   valid;

    // ####################
    // write side.
    // ####################

    // valid bits start clear so every line misses after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_index] <= wr_tag;
        end
    end

    // ####################
    // read side.
    // ####################
    assign tag       = tags[rd_index];  // asynchronous read.
    assign tag_valid = valid[rd_index];

endmodule

/* run.sh */
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it.
# The exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_ifetch -f vlog.f \
    --Mdir obj_dir -o tb_ifetch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/tb_ifetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/mem_model.sv */
/*
 * Behavioral instruction memory for the fetch testbench. Answers each line
 * request with one acknowledge pulse after 1 to 8 cycles. Every word holds
 * its own byte address.
 */
`timescale 1ns/1ns

module mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_req,
    input  icache_pkg::addr_t mem_addr,
    output logic              mem_ack,
    output icache_pkg::line_t mem_data
);

    logic [15:0] lfsr_state;
    int          wait_cycles;
    logic        busy;  // request seen, ack pending or just given.

    // 16-bit Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // three bits, one step each, gives a delay of 1 to 8.
    task automatic draw_delay(output int delay);
        logic [2:0] d;
        d = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            d = {d[1:0], lfsr_state[15]};
        end
        delay = int'(d) + 1;
    endtask

    function automatic icache_pkg::line_t line_of(input icache_pkg::addr_t base);
        icache_pkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = base + 4 * i;  // word equals its byte address.
        end
        return l;
    endfunction

    initial begin
        lfsr_state  = 16'd23718;
        mem_ack     = 1'b0;
        mem_data    = '0;
        busy        = 1'b0;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (!rst_n || !mem_req) begin
                busy = 1'b0;
            end else if (!busy) begin
                busy = 1'b1;
                draw_delay(wait_cycles);
            end else if (wait_cycles > 0) begin
                wait_cycles = wait_cycles - 1;
                if (wait_cycles == 0) begin
                    mem_ack  = 1'b1;  // single pulse, request drops next cycle.
                    mem_data = line_of(mem_addr);
                end
            end
        end
    end

endmodule

/* sim/tb_ifetch.sv */
/*
 * Testbench for the instruction fetch front end. Runs straight-line fetch,
 * a conflicting redirect, an exception window, a pause and a return to the
 * first region, with concurrent assertions doing the checking.
 */
`timescale 1ns/1ns

module tb_ifetch;

    localparam icache_pkg::addr_t RESET_PC    = 32'h0000_0100;  // index 8, tag 0.
    localparam icache_pkg::addr_t CONFLICT_PC = 32'h0000_0300;  // index 8, tag 1.
    localparam icache_pkg::addr_t EXP_PC      = 32'h0000_01C0;  // index 14, tag 0.

    localparam int MAX_FETCHES    = 80;  // upper bound on words over all phases.
    localparam int WORST_MISS     = 12;  // request, 8 delay, ack, fill, issue.
    localparam int TIMEOUT_CYCLES = MAX_FETCHES * WORST_MISS * 4 + 160;

    logic              clk;
    logic              rst_n;
    logic              fetch_en;
    logic              redirect;
    icache_pkg::addr_t redirect_pc;
    logic              ic_exp;
    logic              mem_ack;
    icache_pkg::line_t mem_data;
    logic              inst_valid;
    ifetch_pkg::inst_t inst;
    icache_pkg::addr_t inst_pc;
    logic              mem_req;
    icache_pkg::addr_t mem_addr;

    int                errors = 0;
    int                cycles = 0;
    int                words = 0;
    int                fills = 0;
    int                home_fills = 0;  // fills of the line at RESET_PC.
    string             test_name = "reset";
    icache_pkg::addr_t exp_pc;
    icache_pkg::tag_t  shadow_tag [16];
    logic [15:0]       shadow_valid;
    logic              req_resident;

    ifetch_top #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .redirect(redirect),
        .redirect_pc(redirect_pc), .ic_exp(ic_exp), .mem_ack(mem_ack),
        .mem_data(mem_data), .inst_valid(inst_valid), .inst(inst),
        .inst_pc(inst_pc), .mem_req(mem_req), .mem_addr(mem_addr)
    );

    mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_ack(mem_ack), .mem_data(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ####################
    // reference model.
    // ####################
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc <= RESET_PC;
        end else if (redirect) begin
            exp_pc <= redirect_pc;       // next word starts at the new pc.
        end else if (inst_valid) begin
            exp_pc <= exp_pc + 32'd4;
            words  <= words + 1;
        end
    end

    // shadow tags follow each returned line.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_valid <= '0;
        end else if (mem_ack) begin
            shadow_valid[mem_addr[8:5]] <= 1'b1;
            shadow_tag[mem_addr[8:5]]   <= mem_addr[14:9];
            fills <= fills + 1;
            if (mem_addr == RESET_PC) home_fills <= home_fills + 1;
        end
    end

    assign req_resident = shadow_valid[mem_addr[8:5]] &&
                          (shadow_tag[mem_addr[8:5]] == mem_addr[14:9]);

    // ####################
    // checks.
    // ####################
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |-> (!inst_valid && !mem_req))
        else begin
            errors = errors + 1;
            $display("reset: output active during reset");
        end

    a_word_data: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst == inst_pc)
        else begin
            errors = errors + 1;
            $display("ERROR %s: inst expected %h actual %h", test_name, inst_pc, inst);
        end

    a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid |-> inst_pc == exp_pc)
        else begin
            errors = errors + 1;
            $display("ERROR %s: inst_pc expected %h actual %h", test_name, exp_pc, inst_pc);
        end

    a_req_align: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> mem_addr[4:0] == 5'd0)
        else begin
            errors = errors + 1;
            $display("ERROR %s: mem_addr offset expected 00 actual %h", test_name,
                     mem_addr[4:0]);
        end

    a_req_new_line: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !req_resident)
        else begin
            errors = errors + 1;
            $display("%s: request for line %h that is already cached", test_name, mem_addr);
        end

    a_quiet_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (!fetch_en || ic_exp) |=> !inst_valid)
        else begin
            errors = errors + 1;
            $display("%s: word issued while stalled", test_name);
        end

    a_no_req_in_exp: assert property (@(posedge clk) disable iff (!rst_n)
        ic_exp |=> !$rose(mem_req))
        else begin
            errors = errors + 1;
            $display("%s: request raised under ic_exp", test_name);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: %s still running after %0d cycles, errors %0d",
                     test_name, cycles, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ####################
    // stimulus.
    // ####################
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_pc(input icache_pkg::addr_t target);
        next_cycle();
        while (!(inst_valid && inst_pc == target)) begin
            next_cycle();
        end
    endtask

    task automatic redirect_to(input icache_pkg::addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        next_cycle();
        redirect    = 1'b0;  // one-cycle strobe.
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_en    = 1'b1;  // already fetching while reset is held.
        redirect    = 1'b0;
        redirect_pc = '0;
        ic_exp      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_name = "straight";
        wait_for_pc(RESET_PC + 32'h5C);    // three lines.
        test_name = "conflict";
        redirect_to(CONFLICT_PC);
        wait_for_pc(CONFLICT_PC + 32'h1C);
        assert (shadow_valid[8] && shadow_tag[8] == CONFLICT_PC[14:9])
            else begin
                errors = errors + 1;
                $display("ERROR %s: tag at index 8 expected %h actual %h", test_name,
                         CONFLICT_PC[14:9], shadow_tag[8]);
            end
        test_name = "exception";
        ic_exp    = 1'b1;
        redirect_to(EXP_PC);
        repeat (6) next_cycle();
        ic_exp    = 1'b0;
        wait_for_pc(EXP_PC + 32'h8);
        ic_exp    = 1'b1;                   // line is resident, hits held off.
        repeat (3) next_cycle();
        ic_exp    = 1'b0;
        test_name = "pause";
        fetch_en  = 1'b0;
        repeat (5) next_cycle();
        fetch_en  = 1'b1;
        wait_for_pc(EXP_PC + 32'h1C);
        test_name = "return";
        redirect_to(RESET_PC);              // line was evicted by the conflict.
        wait_for_pc(RESET_PC + 32'h3C);
        assert (home_fills >= 2)
            else begin
                errors = errors + 1;
                $display("ERROR %s: fills of evicted line expected 2 actual %0d",
                         test_name, home_fills);
            end
        repeat (4) next_cycle();
        $display("errors %0d, words %0d, fills %0d, cycles %0d", errors, words, fills, cycles);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/icache_pkg.sv
design/ifetch_pkg.sv
design/icache_if.sv
design/tag_store.sv
design/data_store.sv
design/i_cache.sv
design/fill_ctrl.sv
design/fetch_unit.sv
design/ifetch_top.sv
sim/mem_model.sv
sim/tb_ifetch.sv
